// File: axi_mem_bridge.f
+incdir+.
axi_mem_pkg.sv
axi_burst_decoder.sv
axi_rw_arbiter.sv
axi_resp_router.sv
axi_mem_bridge.sv
axi_mem_bridge_sva.sv
tb_axi_mem_bridge.sv

// File: Makefile
# Verilator flow for the AXI to memory bridge testbench.
TOP := tb_axi_mem_bridge
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f axi_mem_bridge.f --top-module $(TOP) -o $(TOP)

run: build
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation reported a failure."; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "Simulation ended without a result."; exit 1)

lint:
	verilator --lint-only -Wall --timing -f axi_mem_bridge.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: tb_axi_mem_bridge.sv
// Directed testbench for the AXI to memory bridge.
// A random grant, random latency memory model sits on the memory port.
// AXI traffic comes from small driver tasks, and R and B are checked
// against a reference copy of the memory kept by the testbench.

`timescale 1ns/100ps
`include "axi_mem_consts.svh"
`default_nettype none

module tb_axi_mem_bridge import axi_mem_pkg::*; ();

  localparam int TOTAL_BEATS = 58;
  localparam int TIMEOUT_CYC = TOTAL_BEATS * 20;
  // Byte range where the memory flags an error.
  localparam logic [15:0] ERR_LO = 16'h0300;
  localparam logic [15:0] ERR_HI = 16'h033F;

  logic                       clk_i = 1'b0;
  logic                       arst_n_i;
  axi_ax_t                    ar_i, aw_i;
  logic                       ar_valid_i, aw_valid_i, w_valid_i;
  logic                       ar_ready_o, aw_ready_o, w_ready_o;
  axi_w_t                     w_i;
  axi_r_t                     r_o;
  axi_b_t                     b_o;
  logic                       r_valid_o, r_ready_i, b_valid_o, b_ready_i;
  mem_req_t                   mem_req_o;
  logic                       mem_valid_o, mem_gnt_i, mem_rvalid_i, mem_err_i;
  logic [`AXI_MEM_DATA_W-1:0] mem_rdata_i;

  // Memory model contents and the expected contents.
  logic [31:0] mem_arr [256];
  logic [31:0] ref_mem [256];
  // Responses waiting inside the memory model, in order.
  logic [31:0] resp_data_q[$];
  logic        resp_err_q[$];
  int          resp_due_q[$];
  // Every accepted memory request, in order.
  logic        acc_we_q[$];
  logic [15:0] acc_addr_q[$];
  axi_r_t      r_got_q[$];
  axi_b_t      b_got_q[$];
  logic [31:0] wbuf [16];
  int          cycle_cnt = 0;
  int          rd_acc_cnt = 0;
  int          r_hs_cnt = 0;
  // Random R and B ready gaps when set.
  logic        bp_en = 1'b0;
  int          i;

  axi_mem_bridge u_axi_mem_bridge (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .ar_i         (ar_i),
    .ar_valid_i   (ar_valid_i),
    .ar_ready_o   (ar_ready_o),
    .aw_i         (aw_i),
    .aw_valid_i   (aw_valid_i),
    .aw_ready_o   (aw_ready_o),
    .w_i          (w_i),
    .w_valid_i    (w_valid_i),
    .w_ready_o    (w_ready_o),
    .r_o          (r_o),
    .r_valid_o    (r_valid_o),
    .r_ready_i    (r_ready_i),
    .b_o          (b_o),
    .b_valid_o    (b_valid_o),
    .b_ready_i    (b_ready_i),
    .mem_req_o    (mem_req_o),
    .mem_valid_o  (mem_valid_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .mem_err_i    (mem_err_i)
  );

  always #50 clk_i = ~clk_i;

  // Initial memory word, built from the full word index.
  function automatic logic [31:0] fill_word(input int idx);
    fill_word = 32'h5A000000 ^ {idx[7:0], ~idx[7:0], idx[7:0], 8'h3C};
  endfunction

  function automatic logic in_err_window(input logic [15:0] addr);
    in_err_window = (addr >= ERR_LO) && (addr <= ERR_HI);
  endfunction

  // INCR burst of 32-bit words.
  function automatic axi_ax_t make_ax(input logic [3:0] id, input logic [15:0] addr,
                                      input int n, input logic [3:0] qos);
    make_ax = '{id: id, addr: addr, len: 8'(n - 1), size: 3'd2, burst: 2'b01, qos: qos};
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped on the first error.");
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    assert (got === exp)
      else stop_run($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp));
  endtask

  // Memory accepts a request, writes at once and queues the response.
  task automatic take_request(input mem_req_t req);
    logic [7:0] idx;
    logic       err;
    int         b;
    idx = req.addr[9:2];
    err = in_err_window(req.addr);
    acc_we_q.push_back(req.we);
    acc_addr_q.push_back(req.addr);
    if (req.we && !err) begin
      for (b = 0; b < 4; b++) begin
        if (req.strb[b]) mem_arr[idx][8*b +: 8] = req.wdata[8*b +: 8];
      end
    end
    if (!req.we) rd_acc_cnt++;
    resp_data_q.push_back(req.we ? 32'h0 : mem_arr[idx]);
    resp_err_q.push_back(err);
    // Latency of 1 to 4 cycles.
    resp_due_q.push_back(cycle_cnt + int'($urandom_range(3, 0)));
    assert (resp_data_q.size() <= `AXI_MEM_OUTSTANDING)
      else stop_run("More requests were in flight at the memory than allowed.");
    assert (rd_acc_cnt - r_hs_cnt <= `AXI_MEM_OUTSTANDING)
      else stop_run("More reads were issued than the bridge can hold unanswered.");
  endtask

  task automatic drive_response();
    if (resp_due_q.size() != 0 && resp_due_q[0] <= cycle_cnt) begin
      mem_rvalid_i = 1'b1;
      mem_rdata_i  = resp_data_q.pop_front();
      mem_err_i    = resp_err_q.pop_front();
      void'(resp_due_q.pop_front());
    end else begin
      mem_rvalid_i = 1'b0;
      mem_rdata_i  = '0;
      mem_err_i    = 1'b0;
    end
  endtask

  // Memory model and response monitor, sampling at the edge.
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (r_valid_o && r_ready_i) begin
      r_got_q.push_back(r_o);
      r_hs_cnt++;
    end
    if (b_valid_o && b_ready_i) b_got_q.push_back(b_o);
    if (mem_valid_o && mem_gnt_i) take_request(mem_req_o);
    #1;
    mem_gnt_i = ($urandom % 4) != 0;
    r_ready_i = bp_en ? (($urandom % 3) != 0) : 1'b1;
    b_ready_i = bp_en ? (($urandom % 3) != 0) : 1'b1;
    drive_response();
  end

  task automatic send_ar(input axi_ax_t ax);
    ar_i       = ax;
    ar_valid_i = 1'b1;
    do @(posedge clk_i); while (!ar_ready_o);
    #1;
    ar_valid_i = 1'b0;
  endtask

  task automatic send_aw(input axi_ax_t ax);
    aw_i       = ax;
    aw_valid_i = 1'b1;
    do @(posedge clk_i); while (!aw_ready_o);
    #1;
    aw_valid_i = 1'b0;
  endtask

  // W beats back to back from wbuf.
  task automatic send_w(input int n);
    int k;
    for (k = 0; k < n; k++) begin
      w_i       = '{data: wbuf[k], strb: 4'hF, last: (k == n - 1)};
      w_valid_i = 1'b1;
      do @(posedge clk_i); while (!w_ready_o);
      #1;
    end
    w_valid_i = 1'b0;
  endtask

  // Random data burst, the reference skips the error window.
  task automatic write_burst(input logic [3:0] id, input logic [15:0] addr,
                             input int n, input logic [3:0] qos);
    int          k;
    logic [15:0] a;
    for (k = 0; k < n; k++) begin
      wbuf[k] = $urandom;
      a       = (addr & 16'hFFFC) + 16'(4 * k);
      if (!in_err_window(a)) ref_mem[a[9:2]] = wbuf[k];
    end
    fork
      send_aw(make_ax(id, addr, n, qos));
      send_w(n);
    join
  endtask

  task automatic expect_read(input logic [3:0] id, input logic [15:0] addr, input int n);
    int          k;
    logic [15:0] a;
    axi_r_t      r;
    axi_resp_e   exp_resp;
    for (k = 0; k < n; k++) begin
      a        = (addr & 16'hFFFC) + 16'(4 * k);
      exp_resp = in_err_window(a) ? RESP_SLVERR : RESP_OKAY;
      while (r_got_q.size() == 0) begin
        @(posedge clk_i);
        #1;
      end
      r = r_got_q.pop_front();
      check_val("r.id", 32'(r.id), 32'(id));
      check_val("r.resp", 32'(r.resp), 32'(exp_resp));
      check_val("r.last", 32'(r.last), 32'(k == n - 1));
      if (exp_resp == RESP_OKAY) check_val("r.data", r.data, ref_mem[a[9:2]]);
    end
  endtask

  task automatic expect_write_resp(input logic [3:0] id, input axi_resp_e resp);
    axi_b_t b;
    while (b_got_q.size() == 0) begin
      @(posedge clk_i);
      #1;
    end
    b = b_got_q.pop_front();
    check_val("b.id", 32'(b.id), 32'(id));
    check_val("b.resp", 32'(b.resp), 32'(resp));
  endtask

  task automatic single_write_read();
    write_burst(4'd3, 16'h0010, 1, 4'd0);
    expect_write_resp(4'd3, RESP_OKAY);
    send_ar(make_ax(4'd5, 16'h0010, 1, 4'd0));
    expect_read(4'd5, 16'h0010, 1);
  endtask

  // Unaligned start, beats land on consecutive words from 0x100.
  task automatic incr_burst_roundtrip();
    int          start;
    int          k;
    logic [15:0] a;
    start = acc_we_q.size();
    write_burst(4'd1, 16'h0102, 8, 4'd0);
    expect_write_resp(4'd1, RESP_OKAY);
    for (k = 0; k < 8; k++) begin
      a = acc_addr_q[start + k];
      check_val("mem_req.we", 32'(acc_we_q[start + k]), 32'd1);
      check_val("mem_req.addr word", 32'(a[15:2]), 32'(16'h0040 + k));
    end
    send_ar(make_ax(4'd2, 16'h0100, 8, 4'd0));
    expect_read(4'd2, 16'h0100, 8);
    check_val("b count", 32'(b_got_q.size()), 32'd0);
  endtask

  task automatic backpressure_ordering();
    bp_en = 1'b1;
    fork
      write_burst(4'd4, 16'h0200, 4, 4'd0);
      send_ar(make_ax(4'd6, 16'h0100, 6, 4'd0));
    join
    expect_read(4'd6, 16'h0100, 6);
    expect_write_resp(4'd4, RESP_OKAY);
    send_ar(make_ax(4'd7, 16'h0200, 4, 4'd0));
    send_ar(make_ax(4'd8, 16'h0010, 1, 4'd0));
    send_ar(make_ax(4'd9, 16'h0108, 2, 4'd0));
    expect_read(4'd7, 16'h0200, 4);
    expect_read(4'd8, 16'h0010, 1);
    expect_read(4'd9, 16'h0108, 2);
    bp_en = 1'b0;
  endtask

  // Beats at 0x300 and up fall into the error window.
  task automatic error_window_response();
    write_burst(4'd10, 16'h02F8, 4, 4'd0);
    expect_write_resp(4'd10, RESP_SLVERR);
    send_ar(make_ax(4'd11, 16'h02F4, 4, 4'd0));
    expect_read(4'd11, 16'h02F4, 4);
  endtask

  task automatic qos_read_first();
    int start;
    start = acc_we_q.size();
    fork
      send_ar(make_ax(4'd12, 16'h0010, 1, 4'd8));
      write_burst(4'd13, 16'h0020, 1, 4'd1);
    join
    check_val("first mem_req.we", 32'(acc_we_q[start]), 32'd0);
    expect_read(4'd12, 16'h0010, 1);
    expect_write_resp(4'd13, RESP_OKAY);
  endtask

  // Equal QoS after a lone read, so the write burst goes first
  // and its later beats must win against the waiting read.
  task automatic write_burst_not_overtaken();
    int start;
    int writes_seen;
    int k;
    send_ar(make_ax(4'd1, 16'h0010, 1, 4'd2));
    expect_read(4'd1, 16'h0010, 1);
    start       = acc_we_q.size();
    writes_seen = 0;
    fork
      send_ar(make_ax(4'd14, 16'h0100, 4, 4'd2));
      write_burst(4'd15, 16'h0080, 4, 4'd2);
    join
    check_val("first mem_req.we", 32'(acc_we_q[start]), 32'd1);
    expect_read(4'd14, 16'h0100, 4);
    expect_write_resp(4'd15, RESP_OKAY);
    for (k = start; k < acc_we_q.size(); k++) begin
      if (acc_we_q[k]) begin
        writes_seen++;
      end else begin
        assert (writes_seen == 0 || writes_seen == 4)
          else stop_run("A read request overtook an ongoing write burst.");
      end
    end
    send_ar(make_ax(4'd0, 16'h0080, 4, 4'd0));
    expect_read(4'd0, 16'h0080, 4);
  endtask

  // Watchdog, about 20 cycles per beat of all tests.
  initial begin
    repeat (TIMEOUT_CYC) @(posedge clk_i);
    stop_run($sformatf("Timeout: the tests did not finish within %0d clock cycles.",
                       TIMEOUT_CYC));
  end

  initial begin
    void'($urandom(32'h8639dc18));
    arst_n_i     = 1'b0;
    ar_i         = '0;
    aw_i         = '0;
    w_i          = '0;
    ar_valid_i   = 1'b0;
    aw_valid_i   = 1'b0;
    w_valid_i    = 1'b0;
    r_ready_i    = 1'b0;
    b_ready_i    = 1'b0;
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    mem_err_i    = 1'b0;
    for (i = 0; i < 256; i++) begin
      mem_arr[i] = fill_word(i);
      ref_mem[i] = fill_word(i);
    end
    repeat (2) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    @(posedge clk_i);
    #1;
    single_write_read();
    incr_burst_roundtrip();
    backpressure_ordering();
    error_window_response();
    qos_read_first();
    write_burst_not_overtaken();
    if (u_axi_mem_bridge.u_sva.err_cnt == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      stop_run("A bound protocol assertion failed during the run.");
    end
  end

endmodule

`default_nettype wire

// File: axi_mem_bridge_sva.sv
// Protocol checks bound into the AXI to memory bridge.
// Responses and memory requests hold under back-pressure,
// and no valid is raised while reset is applied.

`timescale 1ns/100ps
`default_nettype none

module axi_mem_bridge_sva import axi_mem_pkg::*; (
  input logic     clk_i,
  input logic     arst_n_i,
  input axi_r_t   r_o,
  input logic     r_valid_o,
  input logic     r_ready_i,
  input axi_b_t   b_o,
  input logic     b_valid_o,
  input logic     b_ready_i,
  input mem_req_t mem_req_o,
  input logic     mem_valid_o,
  input logic     mem_gnt_i
);

  // Number of failed assertions, read by the testbench at the end.
  int unsigned err_cnt = 0;

  // R beat waits unchanged for the master.
  a_r_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o))
    else begin
      err_cnt++;
      $error("R beat changed or dropped while r_ready was low");
    end

  // B waits unchanged as well.
  a_b_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_o))
    else begin
      err_cnt++;
      $error("B changed or dropped while b_ready was low");
    end

  // Memory request stays put until granted.
  a_req_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_valid_o && !mem_gnt_i |=> mem_valid_o && $stable(mem_req_o))
    else begin
      err_cnt++;
      $error("Memory request changed or dropped before its grant");
    end

  a_reset_quiet: assert property (@(posedge clk_i)
    !arst_n_i |-> !r_valid_o && !b_valid_o && !mem_valid_o)
    else begin
      err_cnt++;
      $error("A valid output was high during reset");
    end

endmodule

bind axi_mem_bridge axi_mem_bridge_sva u_sva (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .r_o         (r_o),
  .r_valid_o   (r_valid_o),
  .r_ready_i   (r_ready_i),
  .b_o         (b_o),
  .b_valid_o   (b_valid_o),
  .b_ready_i   (b_ready_i),
  .mem_req_o   (mem_req_o),
  .mem_valid_o (mem_valid_o),
  .mem_gnt_i   (mem_gnt_i)
);

`default_nettype wire

// File: axi_mem_bridge.sv
// AXI4 slave to single memory port bridge.
// Decoder splits bursts, arbiter issues word requests,
// router returns the responses as R and B.

`timescale 1ns/100ps
`include "axi_mem_consts.svh"
`default_nettype none

module axi_mem_bridge import axi_mem_pkg::*; (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  // AXI slave port.
  input  axi_ax_t                    ar_i,
  input  logic                       ar_valid_i,
  output logic                       ar_ready_o,
  input  axi_ax_t                    aw_i,
  input  logic                       aw_valid_i,
  output logic                       aw_ready_o,
  input  axi_w_t                     w_i,
  input  logic                       w_valid_i,
  output logic                       w_ready_o,
  output axi_r_t                     r_o,
  output logic                       r_valid_o,
  input  logic                       r_ready_i,
  output axi_b_t                     b_o,
  output logic                       b_valid_o,
  input  logic                       b_ready_i,
  // Memory port, in-order responses.
  output mem_req_t                   mem_req_o,
  output logic                       mem_valid_o,
  input  logic                       mem_gnt_i,
  input  logic                       mem_rvalid_i,
  input  logic [`AXI_MEM_DATA_W-1:0] mem_rdata_i,
  input  logic                       mem_err_i
);

  mem_beat_t rd_beat, wr_beat;
  logic      rd_valid, rd_ready;
  logic      wr_valid, wr_ready;
  mem_meta_t meta;
  logic      meta_push;
  logic      space;

  axi_burst_decoder u_decoder (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .ar_i       (ar_i),
    .ar_valid_i (ar_valid_i),
    .ar_ready_o (ar_ready_o),
    .aw_i       (aw_i),
    .aw_valid_i (aw_valid_i),
    .aw_ready_o (aw_ready_o),
    .w_i        (w_i),
    .w_valid_i  (w_valid_i),
    .w_ready_o  (w_ready_o),
    .rd_beat_o  (rd_beat),
    .rd_valid_o (rd_valid),
    .rd_ready_i (rd_ready),
    .wr_beat_o  (wr_beat),
    .wr_valid_o (wr_valid),
    .wr_ready_i (wr_ready)
  );

  axi_rw_arbiter u_arbiter (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .rd_beat_i   (rd_beat),
    .rd_valid_i  (rd_valid),
    .rd_ready_o  (rd_ready),
    .wr_beat_i   (wr_beat),
    .wr_valid_i  (wr_valid),
    .wr_ready_o  (wr_ready),
    .mem_req_o   (mem_req_o),
    .mem_valid_o (mem_valid_o),
    .mem_gnt_i   (mem_gnt_i),
    .space_i     (space),
    .meta_o      (meta),
    .meta_push_o (meta_push)
  );

  axi_resp_router u_router (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .meta_i       (meta),
    .meta_push_i  (meta_push),
    .space_o      (space),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .mem_err_i    (mem_err_i),
    .r_o          (r_o),
    .r_valid_o    (r_valid_o),
    .r_ready_i    (r_ready_i),
    .b_o          (b_o),
    .b_valid_o    (b_valid_o),
    .b_ready_i    (b_ready_i)
  );

endmodule

`default_nettype wire

// File: axi_resp_router.sv
// Response router of the AXI to memory bridge.
// Pairs in-order memory responses with their queued tags and
// returns them as R beats, or as one B per write burst.

`timescale 1ns/100ps
`include "axi_mem_consts.svh"
`default_nettype none

module axi_resp_router import axi_mem_pkg::*; (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  mem_meta_t                  meta_i,
  input  logic                       meta_push_i,
  output logic                       space_o,
  input  logic                       mem_rvalid_i,
  input  logic [`AXI_MEM_DATA_W-1:0] mem_rdata_i,
  input  logic                       mem_err_i,
  output axi_r_t                     r_o,
  output logic                       r_valid_o,
  input  logic                       r_ready_i,
  output axi_b_t                     b_o,
  output logic                       b_valid_o,
  input  logic                       b_ready_i
);

  localparam int DEPTH = `AXI_MEM_OUTSTANDING;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  mem_meta_t                  meta_mem [DEPTH];
  logic [`AXI_MEM_DATA_W-1:0] data_mem [DEPTH];
  logic                       err_mem  [DEPTH];
  // Both queues drain together, so they share the read pointer.
  logic [PTR_W-1:0] rptr_q, meta_wptr_q, resp_wptr_q;
  logic [CNT_W-1:0] meta_cnt_q, resp_cnt_q;
  // Error seen on an earlier beat of the current write burst.
  logic             sticky_err_q;
  mem_meta_t                  head_meta;
  logic [`AXI_MEM_DATA_W-1:0] head_data;
  logic                       head_err;
  logic                       head_valid;
  logic                       pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    next_ptr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Empty response queue passes the memory response straight through.
  assign head_meta  = meta_mem[rptr_q];
  assign head_valid = (resp_cnt_q != '0) | mem_rvalid_i;
  assign head_data  = (resp_cnt_q != '0) ? data_mem[rptr_q] : mem_rdata_i;
  assign head_err   = (resp_cnt_q != '0) ? err_mem[rptr_q] : mem_err_i;

  assign r_valid_o = head_valid & (head_meta.op == OP_READ);
  assign b_valid_o = head_valid & (head_meta.op == OP_WRITE) & head_meta.last;
  // Inner write beats leave without an AXI response.
  assign pop = (head_meta.op == OP_READ) ? r_valid_o & r_ready_i :
               head_valid & (!head_meta.last | b_ready_i);

  assign r_o = '{data: head_data, id: head_meta.id,
                 resp: head_err ? RESP_SLVERR : RESP_OKAY, last: head_meta.last};
  assign b_o = '{id: head_meta.id,
                 resp: (head_err | sticky_err_q) ? RESP_SLVERR : RESP_OKAY};

  assign space_o = (meta_cnt_q != CNT_W'(DEPTH));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rptr_q       <= '0;
      meta_wptr_q  <= '0;
      resp_wptr_q  <= '0;
      meta_cnt_q   <= '0;
      resp_cnt_q   <= '0;
      sticky_err_q <= 1'b0;
    end else begin
      if (meta_push_i) meta_wptr_q <= next_ptr(meta_wptr_q);
      if (mem_rvalid_i) resp_wptr_q <= next_ptr(resp_wptr_q);
      if (pop) rptr_q <= next_ptr(rptr_q);
      meta_cnt_q <= meta_cnt_q + CNT_W'(meta_push_i) - CNT_W'(pop);
      resp_cnt_q <= resp_cnt_q + CNT_W'(mem_rvalid_i) - CNT_W'(pop);
      if (pop && head_meta.op == OP_WRITE) begin
        sticky_err_q <= head_meta.last ? 1'b0 : (sticky_err_q | head_err);
      end
    end
  end

  // Storage; a bypassed response is written too and popped in place.
  always_ff @(posedge clk_i) begin
    if (meta_push_i) begin
      meta_mem[meta_wptr_q] <= meta_i;
    end
    if (mem_rvalid_i) begin
      data_mem[resp_wptr_q] <= mem_rdata_i;
      err_mem[resp_wptr_q]  <= mem_err_i;
    end
  end

endmodule

`default_nettype wire

// File: axi_rw_arbiter.sv
// Read/write arbiter of the AXI to memory bridge.
// Picks a read or write beat by QoS, ongoing burst and alternation,
// and issues it to the memory port while the router has room.

`timescale 1ns/100ps
`default_nettype none

module axi_rw_arbiter import axi_mem_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  mem_beat_t rd_beat_i,
  input  logic      rd_valid_i,
  output logic      rd_ready_o,
  input  mem_beat_t wr_beat_i,
  input  logic      wr_valid_i,
  output logic      wr_ready_o,
  output mem_req_t  mem_req_o,
  output logic      mem_valid_o,
  input  logic      mem_gnt_i,
  input  logic      space_i,
  output mem_meta_t meta_o,
  output logic      meta_push_o
);

  arb_state_e state_q;
  // Last offered side, also the held choice while locked.
  mem_op_e    sel_q;
  mem_op_e    sel;
  mem_beat_t  beat;
  logic       beat_valid;

  always_comb begin
    sel = sel_q;
    if (state_q == ARB_LOCKED) begin
      // Request pending at the memory, keep the side.
      sel = sel_q;
    end else if (rd_valid_i && wr_valid_i) begin
      if (wr_beat_i.qos > rd_beat_i.qos) begin
        sel = OP_WRITE;
      end else if (rd_beat_i.qos > wr_beat_i.qos) begin
        sel = OP_READ;
      end else if (!wr_beat_i.first) begin
        // Finish an open write burst first.
        sel = OP_WRITE;
      end else if (!rd_beat_i.first) begin
        sel = OP_READ;
      end else begin
        // Plain tie, alternate.
        sel = (sel_q == OP_READ) ? OP_WRITE : OP_READ;
      end
    end else if (wr_valid_i) begin
      sel = OP_WRITE;
    end else if (rd_valid_i) begin
      sel = OP_READ;
    end
  end

  assign beat       = (sel == OP_WRITE) ? wr_beat_i : rd_beat_i;
  assign beat_valid = (sel == OP_WRITE) ? wr_valid_i : rd_valid_i;

  // No issue without a free tag slot downstream.
  assign mem_valid_o = beat_valid & space_i;
  assign rd_ready_o  = (sel == OP_READ) & space_i & mem_gnt_i;
  assign wr_ready_o  = (sel == OP_WRITE) & space_i & mem_gnt_i;
  assign meta_push_o = mem_valid_o & mem_gnt_i;

  assign mem_req_o = '{addr: beat.addr, we: (beat.op == OP_WRITE),
                       wdata: beat.wdata, strb: beat.strb};
  assign meta_o    = '{op: beat.op, id: beat.id, last: beat.last};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ARB_FREE;
      sel_q   <= OP_WRITE;
    end else begin
      state_q <= (mem_valid_o && !mem_gnt_i) ? ARB_LOCKED : ARB_FREE;
      if (mem_valid_o) begin
        sel_q <= sel;
      end
    end
  end

endmodule

`default_nettype wire

// File: axi_burst_decoder.sv
// Burst decoder of the AXI to memory bridge.
// Splits AR and AW/W bursts into single word beats with
// incrementing addresses, one beat stream per direction.

`timescale 1ns/100ps
`include "axi_mem_consts.svh"
`default_nettype none

module axi_burst_decoder import axi_mem_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  axi_ax_t   ar_i,
  input  logic      ar_valid_i,
  output logic      ar_ready_o,
  input  axi_ax_t   aw_i,
  input  logic      aw_valid_i,
  output logic      aw_ready_o,
  input  axi_w_t    w_i,
  input  logic      w_valid_i,
  output logic      w_ready_o,
  output mem_beat_t rd_beat_o,
  output logic      rd_valid_o,
  input  logic      rd_ready_i,
  output mem_beat_t wr_beat_o,
  output logic      wr_valid_o,
  input  logic      wr_ready_i
);

  localparam int ADDR_W = `AXI_MEM_ADDR_W;

  // Remaining beats after the current one, zero when idle.
  logic [`AXI_MEM_LEN_W-1:0] rd_cnt_q, wr_cnt_q;
  // Burst context, addr holds the aligned address of the last issued beat.
  axi_ax_t rd_ax_q, wr_ax_q;

  // Bytes per beat for a given size.
  function automatic logic [ADDR_W-1:0] beat_step(input logic [2:0] size);
    beat_step = ADDR_W'(1) << size;
  endfunction

  function automatic logic [ADDR_W-1:0] align_addr(input logic [ADDR_W-1:0] addr,
                                                   input logic [2:0] size);
    align_addr = addr & ~(beat_step(size) - ADDR_W'(1));
  endfunction

  // Read beats.
  always_comb begin
    rd_beat_o    = '0;
    rd_beat_o.op = OP_READ;
    rd_valid_o   = 1'b0;
    ar_ready_o   = 1'b0;
    if (rd_cnt_q != '0) begin
      // Burst in progress.
      rd_valid_o      = 1'b1;
      rd_beat_o.addr  = rd_ax_q.addr + beat_step(rd_ax_q.size);
      rd_beat_o.id    = rd_ax_q.id;
      rd_beat_o.qos   = rd_ax_q.qos;
      rd_beat_o.last  = (rd_cnt_q == 8'd1);
    end else if (ar_valid_i) begin
      // First beat uses the AXI address as given.
      rd_valid_o      = 1'b1;
      rd_beat_o.addr  = ar_i.addr;
      rd_beat_o.id    = ar_i.id;
      rd_beat_o.qos   = ar_i.qos;
      rd_beat_o.first = 1'b1;
      rd_beat_o.last  = (ar_i.len == '0);
      ar_ready_o      = rd_ready_i;
    end
  end

  // Write beats, each needs its W word.
  always_comb begin
    wr_beat_o       = '0;
    wr_beat_o.op    = OP_WRITE;
    wr_beat_o.wdata = w_i.data;
    wr_beat_o.strb  = w_i.strb;
    wr_valid_o      = 1'b0;
    aw_ready_o      = 1'b0;
    if (wr_cnt_q != '0) begin
      wr_valid_o      = w_valid_i;
      wr_beat_o.addr  = wr_ax_q.addr + beat_step(wr_ax_q.size);
      wr_beat_o.id    = wr_ax_q.id;
      wr_beat_o.qos   = wr_ax_q.qos;
      wr_beat_o.last  = (wr_cnt_q == 8'd1);
    end else if (aw_valid_i) begin
      // AW is taken together with its first W word.
      wr_valid_o      = w_valid_i;
      wr_beat_o.addr  = aw_i.addr;
      wr_beat_o.id    = aw_i.id;
      wr_beat_o.qos   = aw_i.qos;
      wr_beat_o.first = 1'b1;
      wr_beat_o.last  = (aw_i.len == '0);
      aw_ready_o      = w_valid_i & wr_ready_i;
    end
    w_ready_o = wr_valid_o & wr_ready_i;
  end

  // Beat counters move at the beat handshake.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_cnt_q <= '0;
      wr_cnt_q <= '0;
    end else begin
      if (rd_valid_o && rd_ready_i) begin
        rd_cnt_q <= (rd_cnt_q != '0) ? rd_cnt_q - 8'd1 : ar_i.len;
      end
      if (wr_valid_o && wr_ready_i) begin
        wr_cnt_q <= (wr_cnt_q != '0) ? wr_cnt_q - 8'd1 : aw_i.len;
      end
    end
  end

  // Burst context and running address.
  always_ff @(posedge clk_i) begin
    if (rd_valid_o && rd_ready_i) begin
      if (rd_cnt_q != '0) begin
        rd_ax_q.addr <= rd_beat_o.addr;
      end else begin
        rd_ax_q      <= ar_i;
        rd_ax_q.addr <= align_addr(ar_i.addr, ar_i.size);
      end
    end
    if (wr_valid_o && wr_ready_i) begin
      if (wr_cnt_q != '0) begin
        wr_ax_q.addr <= wr_beat_o.addr;
      end else begin
        wr_ax_q      <= aw_i;
        wr_ax_q.addr <= align_addr(aw_i.addr, aw_i.size);
      end
    end
  end

endmodule

`default_nettype wire

// File: axi_mem_pkg.sv
// Types for the AXI to memory bridge.
// Channel payloads, decoded beats, memory requests and response tags.

`include "axi_mem_consts.svh"
`default_nettype none

package axi_mem_pkg;

  typedef enum logic {
    OP_READ,
    OP_WRITE
  } mem_op_e;

  // AXI response encoding, only the two codes this slave returns.
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  typedef enum logic {
    ARB_FREE,
    ARB_LOCKED
  } arb_state_e;

  // AR and AW share one layout.
  typedef struct packed {
    logic [`AXI_MEM_ID_W-1:0]   id;
    logic [`AXI_MEM_ADDR_W-1:0] addr;
    logic [`AXI_MEM_LEN_W-1:0]  len;
    logic [2:0]                 size;
    logic [1:0]                 burst;
    logic [`AXI_MEM_QOS_W-1:0]  qos;
  } axi_ax_t;

  typedef struct packed {
    logic [`AXI_MEM_DATA_W-1:0]   data;
    logic [`AXI_MEM_DATA_W/8-1:0] strb;
    logic                         last;
  } axi_w_t;

  typedef struct packed {
    logic [`AXI_MEM_DATA_W-1:0] data;
    logic [`AXI_MEM_ID_W-1:0]   id;
    axi_resp_e                  resp;
    logic                       last;
  } axi_r_t;

  typedef struct packed {
    logic [`AXI_MEM_ID_W-1:0] id;
    axi_resp_e                resp;
  } axi_b_t;

  // One word access produced by the decoder.
  typedef struct packed {
    mem_op_e                      op;
    logic [`AXI_MEM_ADDR_W-1:0]   addr;
    logic [`AXI_MEM_ID_W-1:0]     id;
    logic [`AXI_MEM_QOS_W-1:0]    qos;
    logic                         first;
    logic                         last;
    logic [`AXI_MEM_DATA_W-1:0]   wdata;
    logic [`AXI_MEM_DATA_W/8-1:0] strb;
  } mem_beat_t;

  typedef struct packed {
    logic [`AXI_MEM_ADDR_W-1:0]   addr;
    logic                         we;
    logic [`AXI_MEM_DATA_W-1:0]   wdata;
    logic [`AXI_MEM_DATA_W/8-1:0] strb;
  } mem_req_t;

  // Tag kept per issued request until its response returns.
  typedef struct packed {
    mem_op_e                  op;
    logic [`AXI_MEM_ID_W-1:0] id;
    logic                     last;
  } mem_meta_t;

endpackage

`default_nettype wire

// File: axi_mem_consts.svh
// Shared widths and queue depth for the AXI to memory bridge.
// Byte addressing, one 32-bit word per memory request.

`ifndef AXI_MEM_CONSTS_SVH
`define AXI_MEM_CONSTS_SVH

// Byte address width on both the AXI and the memory side.
`define AXI_MEM_ADDR_W 16
// Data word width.
`define AXI_MEM_DATA_W 32
// Transaction ID width.
`define AXI_MEM_ID_W 4
// Burst length field, beats minus one.
`define AXI_MEM_LEN_W 8
// Quality of service field.
`define AXI_MEM_QOS_W 4
// Requests in flight, also the depth of the response queues.
`define AXI_MEM_OUTSTANDING 4

`endif
